//--- priv_block.f
rv32i_types_pkg.sv
machine_mode_types_pkg.sv
prv_pipeline_if.sv
csr_prv_if.sv
prv_control.sv
prv_csr_rfile.sv
priv_block.sv
priv_block_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the trap unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f priv_block.f \
  --top-module priv_block_tb -o priv_block_sim

./obj_dir/priv_block_sim | tee sim.log

if grep -q "Finished with no errors" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

//--- priv_block_tb.sv
// Testbench for the machine-mode trap unit
// Drives pipeline flags, interrupt pins and the CSR port,
// checks results against a model of the trap and CSR rules
`timescale 1ns/100ps
`default_nettype none

module priv_block_tb
  import rv32i_types_pkg::*;
  import machine_mode_types_pkg::*;
;

  localparam int        MAX_CYCLES = 2000;
  localparam csr_addr_t UNUSED_CSR = 12'h7c0;
  localparam word_t     IE_MASK    = 32'h1 << MSTATUS_IE_BIT;
  // Flags that load mbadaddr, rank order fault_l .. mal_insn
  localparam logic [8:0] BADADDR_FLAGS = 9'b1_1110_0111;

  logic      clk, reset;
  logic      mal_l, fault_l, mal_s, fault_s;
  logic      mal_insn, fault_insn, illegal_insn, breakpoint, env_m;
  logic      timer_int, soft_int, ext_int, ret;
  addr_t     curr_epc, curr_epc_p4, badaddr;
  logic      intr;
  csr_addr_t csr_addr;
  csr_op_t   csr_op;
  word_t     csr_wdata, csr_rdata;
  logic      csr_wen, csr_invalid;
  addr_t     trap_vector, epc;

  int         errors = 0;
  int         test_errors = 0;
  int         tests_passed = 0;
  int         tests_failed = 0;
  int         cycles = 0;
  // Software view of the CSRs
  word_t      exp_mie, exp_mtvec, exp_mepc, exp_mbadaddr, rnd, e_pc, b_addr;
  logic [8:0] flags;
  // Pin sets as {timer, soft, ext}
  logic [2:0] combos [6] = '{3'b100, 3'b010, 3'b001, 3'b111, 3'b011, 3'b101};

  priv_block u_priv_block (.*);

  always #5 clk = ~clk;

  // Run limit, far above the length of all tests
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: tests did not complete within %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  // ----------------------------------------
  // Concurrent checks
  // ----------------------------------------
  vec_aligned_a : assert property (@(posedge clk) disable iff (reset)
    trap_vector[1:0] == 2'b00 && epc[1:0] == 2'b00)
    else begin
      $display("Trap vector or return address is not word aligned");
      errors++;
    end

  intr_known_a : assert property (@(posedge clk) disable iff (reset) !$isunknown(intr))
    else begin
      $display("Trap strobe is unknown");
      errors++;
    end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  // Cause code for each exception rank, 0 is the lowest
  function automatic logic [3:0] rank_code(input int r);
    case (r)
      0: return 4'd0;
      1: return 4'd1;
      2: return 4'd2;
      3: return 4'd11;
      4: return 4'd3;
      5: return 4'd6;
      6: return 4'd7;
      7: return 4'd4;
      default: return 4'd5;
    endcase
  endfunction

  // Highest set flag wins
  function automatic logic [3:0] expected_ex_code(input logic [8:0] f);
    logic [3:0] code;
    code = 4'd0;
    for (int r = 0; r < 9; r++) begin
      if (f[r]) code = rank_code(r);
    end
    return code;
  endfunction

  function automatic logic [3:0] expected_int_code(input logic [2:0] p);
    if (p[2]) return 4'd7;
    if (p[1]) return 4'd3;
    return 4'd11;
  endfunction

  function automatic word_t pending_bits(input logic [2:0] p);
    word_t m;
    m           = '0;
    m[MTIP_BIT] = p[2];
    m[MSIP_BIT] = p[1];
    m[MEIP_BIT] = p[0];
    return m;
  endfunction

  // ----------------------------------------
  // Checks and stimulus
  // ----------------------------------------
  task automatic check_val(input string name, input word_t exp, input word_t act);
    assert (act === exp) else begin
      $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic apply_flags(input logic [8:0] f);
    {fault_l, mal_l, fault_s, mal_s, breakpoint} = f[8:4];
    {env_m, illegal_insn, fault_insn, mal_insn}  = f[3:0];
  endtask

  // Step past the edge, drop every strobe
  task automatic next_cycle();
    @(posedge clk);
    #1;
    apply_flags(9'h0);
    {timer_int, soft_int, ext_int} = 3'b000;
    ret     = 1'b0;
    csr_wen = 1'b0;
  endtask

  task automatic drive_csr(input csr_op_t op, input csr_addr_t a, input word_t d);
    csr_wen   = 1'b1;
    csr_op    = op;
    csr_addr  = a;
    csr_wdata = d;
  endtask

  task automatic csr_access(input csr_op_t op, input csr_addr_t a, input word_t d);
    next_cycle();
    drive_csr(op, a, d);
  endtask

  task automatic read_expect(input csr_addr_t a, input string name, input word_t exp);
    next_cycle();
    csr_addr = a;
    #1;
    check_val(name, exp, csr_rdata);
  endtask

  task automatic raise_exception(input logic [8:0] f, input addr_t e, input addr_t b);
    next_cycle();
    apply_flags(f);
    curr_epc    = e;
    curr_epc_p4 = e + 32'd4;
    badaddr     = b;
  endtask

  task automatic pulse_interrupt(input logic [2:0] p);
    next_cycle();
    {timer_int, soft_int, ext_int} = p;
  endtask

  task automatic do_ret();
    next_cycle();
    ret = 1'b1;
  endtask

  // Sample the combinational strobe mid cycle
  task automatic check_intr(input logic exp);
    #2;
    check_bit("intr", exp, intr);
  endtask

  // Write, set and clear one CSR, each followed by a readback
  task automatic rmw_check(input csr_addr_t a, input string name, input word_t mask,
                           output word_t final_val);
    word_t model;
    word_t d;
    d     = $urandom;
    model = d & mask;
    csr_access(CSR_WRITE, a, d);
    read_expect(a, name, model);
    d     = $urandom;
    model = (model | d) & mask;
    csr_access(CSR_SET, a, d);
    read_expect(a, name, model);
    d     = $urandom;
    model = (model & ~d) & mask;
    csr_access(CSR_CLEAR, a, d);
    read_expect(a, name, model);
    final_val = model;
  endtask

  task automatic finish_test(input int num, input string name);
    if (errors == test_errors) begin
      tests_passed++;
      $display("Test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", num, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    apply_flags(9'h0);
    {timer_int, soft_int, ext_int, ret} = 4'b0000;
    {curr_epc, curr_epc_p4, badaddr}    = '0;
    csr_addr  = CSR_MSTATUS;
    csr_op    = CSR_WRITE;
    csr_wdata = '0;
    csr_wen   = 1'b0;
    rnd       = $urandom(32'h4592_644b);
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    // Reset values
    check_intr(1'b0);
    read_expect(CSR_MSTATUS, "mstatus", '0);
    read_expect(CSR_MIE, "mie", '0);
    read_expect(CSR_MTVEC, "mtvec", MTVEC_RESET);
    read_expect(CSR_MEPC, "mepc", '0);
    read_expect(CSR_MCAUSE, "mcause", '0);
    read_expect(CSR_MBADADDR, "mbadaddr", '0);
    read_expect(CSR_MIP, "mip", '0);
    check_bit("csr_invalid", 1'b0, csr_invalid);
    read_expect(UNUSED_CSR, "unused csr", '0);
    check_bit("csr_invalid", 1'b1, csr_invalid);
    finish_test(1, "reset values");

    // Software access, low bits of mtvec and mepc read as zero
    rmw_check(CSR_MIE, "mie", 32'hffff_ffff, exp_mie);
    rmw_check(CSR_MTVEC, "mtvec", 32'hffff_fffc, exp_mtvec);
    rmw_check(CSR_MEPC, "mepc", 32'hffff_fffc, exp_mepc);
    check_val("trap_vector", exp_mtvec, trap_vector);
    check_val("epc", exp_mepc, epc);
    csr_access(CSR_WRITE, UNUSED_CSR, $urandom);
    #1;
    check_bit("csr_invalid", 1'b1, csr_invalid);
    read_expect(CSR_MIE, "mie", exp_mie);
    read_expect(CSR_MTVEC, "mtvec", exp_mtvec);
    read_expect(CSR_MEPC, "mepc", exp_mepc);
    read_expect(CSR_MSTATUS, "mstatus", '0);
    read_expect(CSR_MCAUSE, "mcause", '0);
    read_expect(CSR_MBADADDR, "mbadaddr", '0);
    read_expect(CSR_MIP, "mip", '0);
    finish_test(2, "software access");

    // Every single flag, then random subsets
    exp_mbadaddr = '0;
    for (int i = 0; i < 17; i++) begin
      if (i < 9) begin
        flags    = '0;
        flags[i] = 1'b1;
      end else begin
        rnd   = $urandom;
        flags = rnd[8:0];
        if (flags == 9'h0) flags = 9'h100;
      end
      e_pc       = $urandom;
      e_pc[1:0]  = 2'b00;
      b_addr     = $urandom;
      csr_access(CSR_SET, CSR_MSTATUS, IE_MASK);
      raise_exception(flags, e_pc, b_addr);
      check_intr(1'b1);
      exp_mepc = (flags[4] | flags[3]) ? e_pc + 32'd4 : e_pc;
      exp_mepc[1:0] = 2'b00;
      if (|(flags & BADADDR_FLAGS)) exp_mbadaddr = b_addr;
      read_expect(CSR_MCAUSE, "mcause", {28'h0, expected_ex_code(flags)});
      read_expect(CSR_MEPC, "mepc", exp_mepc);
      check_val("epc", exp_mepc, epc);
      read_expect(CSR_MBADADDR, "mbadaddr", exp_mbadaddr);
      read_expect(CSR_MSTATUS, "mstatus", '0);
    end
    finish_test(3, "exceptions");

    // Pending bit one cycle after the pin, trap in the cycle after that
    csr_access(CSR_WRITE, CSR_MIE, pending_bits(3'b111));
    csr_access(CSR_WRITE, CSR_MSTATUS, IE_MASK);
    for (int i = 0; i < 6; i++) begin
      pulse_interrupt(combos[i]);
      check_intr(1'b0);
      next_cycle();
      check_intr(1'b1);
      read_expect(CSR_MIP, "mip", pending_bits(combos[i]));
      read_expect(CSR_MCAUSE, "mcause", {1'b1, 27'h0, expected_int_code(combos[i])});
      read_expect(CSR_MSTATUS, "mstatus", '0);
      csr_access(CSR_CLEAR, CSR_MIP, pending_bits(combos[i]));
      csr_access(CSR_WRITE, CSR_MSTATUS, IE_MASK);
    end
    finish_test(4, "interrupts");

    // Masked while ie is clear, return re-enables
    csr_access(CSR_WRITE, CSR_MSTATUS, '0);
    pulse_interrupt(3'b100);
    check_intr(1'b0);
    repeat (3) begin
      next_cycle();
      check_intr(1'b0);
    end
    read_expect(CSR_MIP, "mip", pending_bits(3'b100));
    do_ret();
    check_intr(1'b0);
    csr_access(CSR_CLEAR, CSR_MIP, pending_bits(3'b100));
    check_intr(1'b1);
    next_cycle();
    check_intr(1'b0);
    read_expect(CSR_MIP, "mip", '0);
    do_ret();
    check_intr(1'b0);
    next_cycle();
    check_intr(1'b0);
    read_expect(CSR_MSTATUS, "mstatus", IE_MASK);
    read_expect(CSR_MCAUSE, "mcause", 32'h8000_0007);
    finish_test(5, "masking and return");

    // Hardware cause wins over a software write in the same cycle
    b_addr = $urandom;
    raise_exception(9'h100, e_pc, b_addr);
    drive_csr(CSR_WRITE, CSR_MCAUSE, $urandom);
    check_intr(1'b1);
    read_expect(CSR_MCAUSE, "mcause", 32'h0000_0005);
    read_expect(CSR_MBADADDR, "mbadaddr", b_addr);
    rnd = $urandom;
    csr_access(CSR_WRITE, CSR_MCAUSE, rnd);
    read_expect(CSR_MCAUSE, "mcause", rnd);
    finish_test(6, "write collision");

    $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- priv_block.sv
// Machine-mode trap unit top level
// Wires pipeline ports and the CSR port to trap control and the CSR file
`timescale 1ns/100ps
`default_nettype none

module priv_block
  import rv32i_types_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  // Pipeline side
  input  logic      mal_l,
  input  logic      fault_l,
  input  logic      mal_s,
  input  logic      fault_s,
  input  logic      mal_insn,
  input  logic      fault_insn,
  input  logic      illegal_insn,
  input  logic      breakpoint,
  input  logic      env_m,
  input  logic      timer_int,
  input  logic      soft_int,
  input  logic      ext_int,
  input  logic      ret,
  input  addr_t     curr_epc,
  input  addr_t     curr_epc_p4,
  input  addr_t     badaddr,
  output logic      intr,
  // Software CSR port
  input  csr_addr_t csr_addr,
  input  csr_op_t   csr_op,
  input  word_t     csr_wdata,
  input  logic      csr_wen,
  output word_t     csr_rdata,
  output logic      csr_invalid,
  // Trap target and return address
  output addr_t     trap_vector,
  output addr_t     epc
);

  prv_pipeline_if prv_pipe_if ();
  csr_prv_if      csr_pr_if (.clk(clk));

  // Pipeline ports onto the interface
  assign prv_pipe_if.mal_l        = mal_l;
  assign prv_pipe_if.fault_l      = fault_l;
  assign prv_pipe_if.mal_s        = mal_s;
  assign prv_pipe_if.fault_s      = fault_s;
  assign prv_pipe_if.mal_insn     = mal_insn;
  assign prv_pipe_if.fault_insn   = fault_insn;
  assign prv_pipe_if.illegal_insn = illegal_insn;
  assign prv_pipe_if.breakpoint   = breakpoint;
  assign prv_pipe_if.env_m        = env_m;
  assign prv_pipe_if.timer_int    = timer_int;
  assign prv_pipe_if.soft_int     = soft_int;
  assign prv_pipe_if.ext_int      = ext_int;
  assign prv_pipe_if.ret          = ret;
  assign prv_pipe_if.curr_epc     = curr_epc;
  assign prv_pipe_if.curr_epc_p4  = curr_epc_p4;
  assign prv_pipe_if.badaddr      = badaddr;
  assign intr                     = prv_pipe_if.intr;

  prv_control u_prv_control (
    .prv_pipe_if (prv_pipe_if),
    .csr_pr_if   (csr_pr_if)
  );

  prv_csr_rfile u_prv_csr_rfile (
    .clk         (clk),
    .reset       (reset),
    .csr_pr_if   (csr_pr_if),
    .csr_addr    (csr_addr),
    .csr_op      (csr_op),
    .csr_wdata   (csr_wdata),
    .csr_wen     (csr_wen),
    .csr_rdata   (csr_rdata),
    .csr_invalid (csr_invalid),
    .trap_vector (trap_vector),
    .epc         (epc)
  );

endmodule

`default_nettype wire

//--- prv_csr_rfile.sv
// Machine CSR register file
// Holds mstatus.ie, mie, mip, mtvec, mepc, mcause and mbadaddr,
// with a hardware update port and a software read/write/set/clear port
`timescale 1ns/100ps
`default_nettype none

module prv_csr_rfile
  import rv32i_types_pkg::*;
  import machine_mode_types_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  csr_prv_if.csr    csr_pr_if,
  input  csr_addr_t csr_addr,
  input  csr_op_t   csr_op,
  input  word_t     csr_wdata,
  input  logic      csr_wen,
  output word_t     csr_rdata,
  output logic      csr_invalid,
  output addr_t     trap_vector,
  output addr_t     epc
);

  // Only the global enable of mstatus is implemented
  logic   mstatus_ie;
  word_t  mstatus_word;
  word_t  mie_q;
  word_t  mip_q;
  addr_t  mtvec_q;
  addr_t  mepc_q;
  cause_t mcause_q;
  addr_t  mbadaddr_q;

  // Software write value and per-register write enables
  word_t sw_value;
  logic  wr_mstatus, wr_mie, wr_mip, wr_mtvec;
  logic  wr_mepc, wr_mcause, wr_mbadaddr;

  always_comb begin
    mstatus_word                 = '0;
    mstatus_word[MSTATUS_IE_BIT] = mstatus_ie;
  end

  // ----------------------------------------
  // Software read port
  // ----------------------------------------
  always_comb begin
    csr_rdata   = '0;
    csr_invalid = 1'b0;
    case (csr_addr)
      CSR_MSTATUS:  csr_rdata = mstatus_word;
      CSR_MIE:      csr_rdata = mie_q;
      CSR_MTVEC:    csr_rdata = mtvec_q;
      CSR_MEPC:     csr_rdata = mepc_q;
      CSR_MCAUSE:   csr_rdata = mcause_q;
      CSR_MBADADDR: csr_rdata = mbadaddr_q;
      CSR_MIP:      csr_rdata = mip_q;
      default:      csr_invalid = 1'b1;
    endcase
  end

  // Read-modify-write on the current value
  always_comb begin
    case (csr_op)
      CSR_SET:   sw_value = csr_rdata | csr_wdata;
      CSR_CLEAR: sw_value = csr_rdata & ~csr_wdata;
      default:   sw_value = csr_wdata;
    endcase
  end

  // Unknown addresses match nothing, so they write nothing
  assign wr_mstatus  = csr_wen && (csr_addr == CSR_MSTATUS);
  assign wr_mie      = csr_wen && (csr_addr == CSR_MIE);
  assign wr_mtvec    = csr_wen && (csr_addr == CSR_MTVEC);
  assign wr_mepc     = csr_wen && (csr_addr == CSR_MEPC);
  assign wr_mcause   = csr_wen && (csr_addr == CSR_MCAUSE);
  assign wr_mbadaddr = csr_wen && (csr_addr == CSR_MBADADDR);
  assign wr_mip      = csr_wen && (csr_addr == CSR_MIP);

  // ----------------------------------------
  // Registers, hardware strobes win
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      mstatus_ie <= 1'b0;
      mie_q      <= '0;
      mip_q      <= '0;
      mtvec_q    <= MTVEC_RESET;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mbadaddr_q <= '0;
    end else begin
      if (csr_pr_if.mstatus_rup) begin
        mstatus_ie <= csr_pr_if.mstatus_next[MSTATUS_IE_BIT];
      end else if (wr_mstatus) begin
        mstatus_ie <= sw_value[MSTATUS_IE_BIT];
      end

      // No hardware path into mie or mtvec
      if (wr_mie) begin
        mie_q <= sw_value;
      end
      if (wr_mtvec) begin
        mtvec_q <= {sw_value[31:2], 2'b00};
      end

      if (csr_pr_if.mip_rup) begin
        mip_q <= csr_pr_if.mip_next;
      end else if (wr_mip) begin
        mip_q <= sw_value;
      end

      // Return address kept word aligned
      if (csr_pr_if.mepc_rup) begin
        mepc_q <= {csr_pr_if.mepc_next[31:2], 2'b00};
      end else if (wr_mepc) begin
        mepc_q <= {sw_value[31:2], 2'b00};
      end

      if (csr_pr_if.mcause_rup) begin
        mcause_q <= csr_pr_if.mcause_next;
      end else if (wr_mcause) begin
        mcause_q <= sw_value;
      end

      if (csr_pr_if.mbadaddr_rup) begin
        mbadaddr_q <= csr_pr_if.mbadaddr_next;
      end else if (wr_mbadaddr) begin
        mbadaddr_q <= sw_value;
      end
    end
  end

  // Current values back to the trap logic and the pipeline
  assign csr_pr_if.mstatus = mstatus_word;
  assign csr_pr_if.mie     = mie_q;
  assign csr_pr_if.mip     = mip_q;
  assign trap_vector       = mtvec_q;
  assign epc               = mepc_q;

  // Software op must be one of the three legal encodings
  csr_op_known_a : assert property (@(posedge clk) disable iff (reset)
    csr_wen |-> !$isunknown(csr_op) && (csr_op inside {CSR_WRITE, CSR_SET, CSR_CLEAR}));

  // mcause moves only after a trap or a software write to it
  mcause_stable_a : assert property (@(posedge clk) disable iff (reset)
    !(csr_pr_if.mcause_rup || wr_mcause) |=> $stable(mcause_q));

endmodule

`default_nettype wire

//--- prv_control.sv
// Machine-mode trap control
// Ranks exceptions and enabled interrupts, raises the trap strobe
// and computes every CSR update for the register file
`timescale 1ns/100ps
`default_nettype none

module prv_control
  import rv32i_types_pkg::*;
  import machine_mode_types_pkg::*;
(
  prv_pipeline_if.prv prv_pipe_if,
  csr_prv_if.prv      csr_pr_if
);

  ex_code_t                ex_src;
  logic                    exception;
  int_code_t               intr_src;
  logic                    interrupt;
  word_t                   pend_en;
  logic                    trap;
  logic [CAUSE_CODE_W-1:0] cause_code;

  // ----------------------------------------
  // Interrupt pending latch
  // ----------------------------------------
  // Pins only set bits, software clears them through mip
  assign csr_pr_if.mip_rup = prv_pipe_if.timer_int | prv_pipe_if.soft_int |
                             prv_pipe_if.ext_int;

  always_comb begin
    csr_pr_if.mip_next = csr_pr_if.mip;
    if (prv_pipe_if.timer_int) begin
      csr_pr_if.mip_next[MTIP_BIT] = 1'b1;
    end
    if (prv_pipe_if.soft_int) begin
      csr_pr_if.mip_next[MSIP_BIT] = 1'b1;
    end
    // External pin has its own pending bit
    if (prv_pipe_if.ext_int) begin
      csr_pr_if.mip_next[MEIP_BIT] = 1'b1;
    end
  end

  // Pending and enabled, same bit positions in both registers
  assign pend_en = csr_pr_if.mip & csr_pr_if.mie;

  // Interrupt select, timer first, then soft, then external
  // Cause comes from the latched bits so it names what actually fired
  always_comb begin
    interrupt = csr_pr_if.mstatus[MSTATUS_IE_BIT];
    intr_src  = SOFT_INT;
    if (pend_en[MTIP_BIT]) begin
      intr_src = TIMER_INT;
    end else if (pend_en[MSIP_BIT]) begin
      intr_src = SOFT_INT;
    end else if (pend_en[MEIP_BIT]) begin
      intr_src = EXT_INT;
    end else begin
      interrupt = 1'b0;
    end
  end

  // ----------------------------------------
  // Exception priority
  // ----------------------------------------
  always_comb begin
    exception = 1'b1;
    ex_src    = INSN_MAL;
    if (prv_pipe_if.fault_l) begin
      ex_src = L_FAULT;
    end else if (prv_pipe_if.mal_l) begin
      ex_src = L_ADDR_MAL;
    end else if (prv_pipe_if.fault_s) begin
      ex_src = S_FAULT;
    end else if (prv_pipe_if.mal_s) begin
      ex_src = S_ADDR_MAL;
    end else if (prv_pipe_if.breakpoint) begin
      ex_src = BREAKPOINT;
    end else if (prv_pipe_if.env_m) begin
      ex_src = ENV_CALL_M;
    end else if (prv_pipe_if.illegal_insn) begin
      ex_src = ILLEGAL_INSN;
    end else if (prv_pipe_if.fault_insn) begin
      ex_src = INSN_FAULT;
    end else if (prv_pipe_if.mal_insn) begin
      ex_src = INSN_MAL;
    end else begin
      exception = 1'b0;
    end
  end

  // Any exception beats any interrupt
  assign trap             = exception | interrupt;
  assign prv_pipe_if.intr = trap;

  // ----------------------------------------
  // CSR updates on a trap
  // ----------------------------------------
  always_comb begin
    if (exception) begin
      cause_code = ex_src;
    end else begin
      cause_code = intr_src;
    end
    csr_pr_if.mcause_next                     = '0;
    csr_pr_if.mcause_next[CAUSE_INT_BIT]      = ~exception;
    csr_pr_if.mcause_next[CAUSE_CODE_W-1:0]   = cause_code;
  end
  assign csr_pr_if.mcause_rup = trap;

  // Trap clears the global enable, return sets it when no trap competes
  assign csr_pr_if.mstatus_rup = trap | prv_pipe_if.ret;
  always_comb begin
    csr_pr_if.mstatus_next = csr_pr_if.mstatus;
    if (trap) begin
      csr_pr_if.mstatus_next[MSTATUS_IE_BIT] = 1'b0;
    end else if (prv_pipe_if.ret) begin
      csr_pr_if.mstatus_next[MSTATUS_IE_BIT] = 1'b1;
    end
  end

  // ebreak / ecall resume past the instruction, selected on the raw flags
  assign csr_pr_if.mepc_rup  = trap;
  assign csr_pr_if.mepc_next = (exception & (prv_pipe_if.breakpoint | prv_pipe_if.env_m)) ?
                               prv_pipe_if.curr_epc_p4 : prv_pipe_if.curr_epc;

  // Faulting address for address, fault and illegal exceptions
  assign csr_pr_if.mbadaddr_rup  = prv_pipe_if.mal_l | prv_pipe_if.fault_l |
                                   prv_pipe_if.mal_s | prv_pipe_if.fault_s |
                                   prv_pipe_if.illegal_insn | prv_pipe_if.fault_insn |
                                   prv_pipe_if.mal_insn;
  assign csr_pr_if.mbadaddr_next = prv_pipe_if.badaddr;

  // Every trap must leave the global enable clear after its edge
  trap_clears_ie_a : assert property (@(posedge csr_pr_if.clk)
    prv_pipe_if.intr |=> !csr_pr_if.mstatus[MSTATUS_IE_BIT]);

endmodule

`default_nettype wire

//--- csr_prv_if.sv
// CSR state and update interface
// Current machine CSR values out of the register file, update strobes back in
`timescale 1ns/100ps
`default_nettype none

interface csr_prv_if
  import rv32i_types_pkg::*;
  import machine_mode_types_pkg::*;
(
  input logic clk
);

  // Current CSR values
  word_t mstatus, mie, mip;

  // Update requests, strobe loads value at the next rising edge
  logic   mip_rup;
  word_t  mip_next;
  logic   mstatus_rup;
  word_t  mstatus_next;
  logic   mcause_rup;
  cause_t mcause_next;
  logic   mepc_rup;
  addr_t  mepc_next;
  logic   mbadaddr_rup;
  addr_t  mbadaddr_next;

  // Trap side, clock only used for checks
  modport prv (
    input  clk,
    input  mstatus, mie, mip,
    output mip_rup, mip_next, mstatus_rup, mstatus_next,
    output mcause_rup, mcause_next, mepc_rup, mepc_next,
    output mbadaddr_rup, mbadaddr_next
  );

  modport csr (
    output mstatus, mie, mip,
    input  mip_rup, mip_next, mstatus_rup, mstatus_next,
    input  mcause_rup, mcause_next, mepc_rup, mepc_next,
    input  mbadaddr_rup, mbadaddr_next
  );

endinterface

`default_nettype wire

//--- prv_pipeline_if.sv
// Pipeline to trap control interface
// Exception flags, interrupt pins and trap PCs in, trap strobe out
`timescale 1ns/100ps
`default_nettype none

interface prv_pipeline_if
  import rv32i_types_pkg::*;
;

  // Load / store faults and misalignment
  logic mal_l, fault_l, mal_s, fault_s;
  // Fetch and decode exceptions
  logic mal_insn, fault_insn, illegal_insn, breakpoint, env_m;
  // Interrupt pins, level
  logic timer_int, soft_int, ext_int;

  // Return from trap, and PCs of the trapping instruction
  logic  ret;
  addr_t curr_epc, curr_epc_p4, badaddr;

  // Trap taken this cycle
  logic intr;

  modport prv (
    input  mal_l, fault_l, mal_s, fault_s,
    input  mal_insn, fault_insn, illegal_insn, breakpoint, env_m,
    input  timer_int, soft_int, ext_int,
    input  ret, curr_epc, curr_epc_p4, badaddr,
    output intr
  );

  modport pipe (
    output mal_l, fault_l, mal_s, fault_s,
    output mal_insn, fault_insn, illegal_insn, breakpoint, env_m,
    output timer_int, soft_int, ext_int,
    output ret, curr_epc, curr_epc_p4, badaddr,
    input  intr
  );

endinterface

`default_nettype wire

//--- machine_mode_types_pkg.sv
// Machine-mode privileged definitions
// Trap cause codes, CSR addresses, bit positions and reset values
`default_nettype none

package machine_mode_types_pkg;

  // ----------------------------------------
  // mcause layout
  // ----------------------------------------
  localparam int CAUSE_W       = 32;
  localparam int CAUSE_CODE_W  = 4;
  // Set for interrupts, clear for synchronous exceptions
  localparam int CAUSE_INT_BIT = CAUSE_W - 1;

  // Synchronous exception codes
  typedef enum logic [CAUSE_CODE_W-1:0] {
    INSN_MAL     = 4'd0,
    INSN_FAULT   = 4'd1,
    ILLEGAL_INSN = 4'd2,
    BREAKPOINT   = 4'd3,
    L_ADDR_MAL   = 4'd4,
    L_FAULT      = 4'd5,
    S_ADDR_MAL   = 4'd6,
    S_FAULT      = 4'd7,
    ENV_CALL_M   = 4'd11
  } ex_code_t;

  // Machine-level interrupt codes
  typedef enum logic [CAUSE_CODE_W-1:0] {
    SOFT_INT  = 4'd3,
    TIMER_INT = 4'd7,
    EXT_INT   = 4'd11
  } int_code_t;

  // Interrupt flag in bit 31, code in the low bits
  typedef logic [CAUSE_W-1:0] cause_t;

  // ----------------------------------------
  // Bit positions
  // ----------------------------------------
  // Global machine interrupt enable in mstatus
  localparam int MSTATUS_IE_BIT = 3;

  // Pending bits in mip
  // mie uses the same positions for msie / mtie / meie
  localparam int MSIP_BIT = 3;
  localparam int MTIP_BIT = 7;
  localparam int MEIP_BIT = 11;

  // ----------------------------------------
  // CSR addresses
  // ----------------------------------------
  localparam logic [11:0] CSR_MSTATUS  = 12'h300;
  localparam logic [11:0] CSR_MIE      = 12'h304;
  localparam logic [11:0] CSR_MTVEC    = 12'h305;
  localparam logic [11:0] CSR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_MCAUSE   = 12'h342;
  localparam logic [11:0] CSR_MBADADDR = 12'h343;
  localparam logic [11:0] CSR_MIP      = 12'h344;

  // Trap vector after reset, word aligned
  localparam logic [31:0] MTVEC_RESET = 32'h0000_0100;

endpackage

`default_nettype wire

//--- rv32i_types_pkg.sv
// RV32I base types
// Data word, address and CSR address widths, plus the CSR access operation
`default_nettype none

package rv32i_types_pkg;

  // ----------------------------------------
  // Widths fixed by the ISA
  // ----------------------------------------
  localparam int WORD_W     = 32;
  localparam int CSR_ADDR_W = 12;

  // Data word and byte address
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [WORD_W-1:0] addr_t;

  // Flat 4K CSR address space
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

  // Software CSR access, encoded as funct3[1:0] of CSRRW / CSRRS / CSRRC
  // 2'b00 is not a legal operation
  typedef enum logic [1:0] {
    CSR_WRITE = 2'b01,
    CSR_SET   = 2'b10,
    CSR_CLEAR = 2'b11
  } csr_op_t;

endpackage

`default_nettype wire
